/* logic/ahb_params.svh */
// Bus widths and SRAM slave settings shared by the package and RTL
// Include in any file that needs the widths or the SRAM geometry

`ifndef AHB_PARAMS_SVH
`define AHB_PARAMS_SVH

// Address bus width
`define W_ADDR 32

// Data bus width, a whole number of byte lanes
`define W_DATA 32

// SRAM depth in words
// Byte addresses at or above W_DATA/8 times this value are out of range
`define SRAM_WORDS 256

// Wait cycles inserted into every data phase, zero or more
`define SRAM_WAIT 1

`endif

/* logic/ahb_pkg.sv */
// Types for the single-master AHB-Lite bus and the two core-side ports
// Compile first and take the types by wildcard import

`include "ahb_params.svh"

package ahb_pkg;

	// Only single transfers on this bus
	typedef enum logic [1:0] {
		HTRANS_IDLE = 2'b00,
		HTRANS_NSEQ = 2'b10
	} htrans_t;

	// Core-side request, held by the core until aph_ready
	typedef struct packed {
		logic              req;
		logic [`W_ADDR-1:0] addr;
		// Log2 of the transfer size in bytes
		logic [2:0]        size;
		logic              write;
		// Sampled in the data phase, not the address phase
		logic [`W_DATA-1:0] wdata;
	} core_req_t;

	// Core-side response pulses and read data
	typedef struct packed {
		logic              aph_ready;
		logic              dph_ready;
		logic              dph_err;
		logic [`W_DATA-1:0] rdata;
	} core_resp_t;

	// Master to slave
	typedef struct packed {
		logic [`W_ADDR-1:0] haddr;
		htrans_t           htrans;
		logic              hwrite;
		logic [2:0]        hsize;
		logic [`W_DATA-1:0] hwdata;
	} ahb_m2s_t;

	// Slave to master
	typedef struct packed {
		logic              hready;
		logic              hresp;
		logic [`W_DATA-1:0] hrdata;
	} ahb_s2m_t;

endpackage

/* logic/ahb_bus_arbiter.sv */
// Shares one AHB-Lite master port between the fetch and load/store ports
// Address phase goes to one port per cycle, data phase routed by owner flags

`include "ahb_params.svh"

module ahb_bus_arbiter import ahb_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,

	input  core_req_t  fetch_req_i,
	input  logic       fetch_panic_i,
	input  core_req_t  ls_req_i,
	output core_resp_t fetch_resp_o,
	output core_resp_t ls_resp_o,

	output ahb_m2s_t   bus_o,
	input  ahb_s2m_t   bus_i
);

// ------------------------------------------------------------
// Address phase arbitration

logic grant_fetch;
logic grant_ls;
logic hready;

// Data-phase owner flags
logic dph_fetch_q;
logic dph_ls_q;

assign hready = bus_i.hready;

// Load/store normally wins
// Panic lets a starved fetch jump ahead
assign grant_fetch = fetch_req_i.req && (fetch_panic_i || !ls_req_i.req);
assign grant_ls    = ls_req_i.req && !grant_fetch;

always_comb begin
	bus_o.htrans = (grant_fetch || grant_ls) ? HTRANS_NSEQ : HTRANS_IDLE;
	if (grant_fetch) begin
		bus_o.haddr  = fetch_req_i.addr;
		bus_o.hsize  = fetch_req_i.size;
		// Fetch is read-only
		bus_o.hwrite = 1'b0;
	end else begin
		bus_o.haddr  = ls_req_i.addr;
		bus_o.hsize  = ls_req_i.size;
		bus_o.hwrite = grant_ls && ls_req_i.write;
	end
	// Write data belongs to the current data phase
	bus_o.hwdata = dph_ls_q ? ls_req_i.wdata : '0;
end

// ------------------------------------------------------------
// Data phase ownership

// Advances only with hready, same as the AHB pipeline
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		dph_fetch_q <= 1'b0;
		dph_ls_q    <= 1'b0;
	end else if (hready) begin
		dph_fetch_q <= grant_fetch;
		dph_ls_q    <= grant_ls;
	end
end

// ------------------------------------------------------------
// Responses

always_comb begin
	fetch_resp_o.aph_ready = hready && grant_fetch;
	fetch_resp_o.dph_ready = hready && dph_fetch_q;
	// Fetch only sees the error with the final ready
	fetch_resp_o.dph_err   = hready && dph_fetch_q && bus_i.hresp;
	fetch_resp_o.rdata     = dph_fetch_q ? bus_i.hrdata : '0;

	ls_resp_o.aph_ready = hready && grant_ls;
	ls_resp_o.dph_ready = hready && dph_ls_q;
	// Early error in the first response cycle
	// lets the core squash a chasing load/store
	ls_resp_o.dph_err   = dph_ls_q && bus_i.hresp;
	ls_resp_o.rdata     = dph_ls_q ? bus_i.hrdata : '0;
end

// ------------------------------------------------------------
// Checks

// One data phase on the bus at a time
a_one_dph_owner: assert property (
	@(posedge clk) disable iff (!rst_n)
	!(dph_fetch_q && dph_ls_q)
) else $error("both ports own the data phase");

// Shared address phase, so never accepted on both ports at once
a_one_aph_ready: assert property (
	@(posedge clk) disable iff (!rst_n)
	!(fetch_resp_o.aph_ready && ls_resp_o.aph_ready)
) else $error("aph_ready given to both ports");

endmodule

/* logic/ahb_sram_slave.sv */
// AHB-Lite SRAM slave with fixed wait states and byte-lane writes
// Out-of-range addresses get the two-cycle error response, memory untouched

`include "ahb_params.svh"

module ahb_sram_slave import ahb_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  ahb_m2s_t bus_i,
	output ahb_s2m_t bus_o
);

localparam int N_LANES  = `W_DATA / 8;
localparam int W_LANE   = $clog2(N_LANES);
localparam int W_IDX    = $clog2(`SRAM_WORDS);
// Error needs at least one low-hready cycle
localparam int ERR_LAST = (`SRAM_WAIT > 0) ? `SRAM_WAIT : 1;
localparam int W_CNT    = $clog2(ERR_LAST + 1);
localparam logic [`W_ADDR-1:0] ADDR_LIMIT = `W_ADDR'(N_LANES * `SRAM_WORDS);

logic [`W_DATA-1:0] mem [`SRAM_WORDS];

// Data phase control
logic             dph_valid_q;
logic             dph_write_q;
logic             dph_err_q;
logic [W_CNT-1:0] wait_cnt_q;
logic [W_CNT-1:0] last_cnt;

// Data phase payload
logic [W_IDX-1:0]  dph_idx_q;
logic [W_LANE-1:0] dph_lane_q;
logic [2:0]        dph_size_q;

logic               hready;
logic               aph_take;
logic               aph_err;
logic               mem_we;
logic [N_LANES-1:0] byte_en;

// ------------------------------------------------------------
// Address phase

assign aph_err  = bus_i.haddr >= ADDR_LIMIT;
assign aph_take = hready && (bus_i.htrans == HTRANS_NSEQ);

// Counter value of the final data-phase cycle
assign last_cnt = dph_err_q ? W_CNT'(ERR_LAST) : W_CNT'(`SRAM_WAIT);
assign hready   = !dph_valid_q || (wait_cnt_q == last_cnt);

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		dph_valid_q <= 1'b0;
		dph_write_q <= 1'b0;
		dph_err_q   <= 1'b0;
		wait_cnt_q  <= '0;
	end else if (hready) begin
		dph_valid_q <= aph_take;
		dph_write_q <= bus_i.hwrite;
		dph_err_q   <= aph_err;
		wait_cnt_q  <= '0;
	end else begin
		// Stalled data phase
		wait_cnt_q  <= wait_cnt_q + 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (aph_take) begin
		dph_idx_q  <= bus_i.haddr[W_LANE +: W_IDX];
		dph_lane_q <= bus_i.haddr[W_LANE-1:0];
		dph_size_q <= bus_i.hsize;
	end
end

// ------------------------------------------------------------
// Data phase

// Lanes picked by size and low address bits
always_comb begin
	case (dph_size_q)
		3'd0:    byte_en = N_LANES'(1) << dph_lane_q;
		3'd1:    byte_en = N_LANES'(3) << {dph_lane_q[W_LANE-1:1], 1'b0};
		default: byte_en = '1;
	endcase
end

// Write lands in the last cycle, when hwdata is final
assign mem_we = dph_valid_q && hready && dph_write_q && !dph_err_q;

always_ff @(posedge clk) begin
	if (mem_we) begin
		for (int b = 0; b < N_LANES; b++) begin
			if (byte_en[b])
				mem[dph_idx_q][8*b +: 8] <= bus_i.hwdata[8*b +: 8];
		end
	end
end

always_comb begin
	bus_o.hready = hready;
	// Error in the last two cycles, first with hready low
	bus_o.hresp  = dph_valid_q && dph_err_q &&
		((wait_cnt_q == last_cnt) || (wait_cnt_q == last_cnt - 1'b1));
	// Whole word on reads
	bus_o.hrdata = (dph_valid_q && !dph_write_q && !dph_err_q) ? mem[dph_idx_q] : '0;
end

// NONSEQ address must be aligned to its size
a_nseq_aligned: assert property (
	@(posedge clk) disable iff (!rst_n)
	aph_take |-> ((bus_i.haddr & ((`W_ADDR'(1) << bus_i.hsize) - 1'b1)) == '0)
) else $error("misaligned NONSEQ address %h size %0d", bus_i.haddr, bus_i.hsize);

endmodule

/* logic/cpu_bus_subsystem.sv */
// Bus side of the core: fetch and load/store ports share one AHB-Lite bus
// The arbiter masters the bus, an on-chip SRAM slave sits behind it

`include "ahb_params.svh"

module cpu_bus_subsystem import ahb_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,

	// Instruction fetch port
	input  core_req_t  fetch_req_i,
	input  logic       fetch_panic_i,
	output core_resp_t fetch_resp_o,

	// Load/store port
	input  core_req_t  ls_req_i,
	output core_resp_t ls_resp_o
);

// ------------------------------------------------------------
// Shared AHB-Lite bus

ahb_m2s_t bus_m2s;
ahb_s2m_t bus_s2m;

// ------------------------------------------------------------
// Master side

ahb_bus_arbiter u_arbiter (
	.clk           (clk),
	.rst_n         (rst_n),
	.fetch_req_i   (fetch_req_i),
	.fetch_panic_i (fetch_panic_i),
	.ls_req_i      (ls_req_i),
	.fetch_resp_o  (fetch_resp_o),
	.ls_resp_o     (ls_resp_o),
	.bus_o         (bus_m2s),
	.bus_i         (bus_s2m)
);

// ------------------------------------------------------------
// Slave side

// Wait states and address range set in the params header
ahb_sram_slave u_sram (
	.clk   (clk),
	.rst_n (rst_n),
	.bus_i (bus_m2s),
	.bus_o (bus_s2m)
);

endmodule

/* testbench/tb_cpu_bus_subsystem.sv */
// Testbench for the shared-bus subsystem driving both core ports
// A reference memory predicts every data phase as it completes

`include "ahb_params.svh"

module tb_cpu_bus_subsystem import ahb_pkg::*;;

timeunit 1ns;
timeprecision 1ps;

// Transfers per test set the timeout
localparam int N_XFERS     = 2 + 32 + 13 + 5 + 5 + 24;
localparam int CYCLE_LIMIT = N_XFERS * (`SRAM_WAIT + 3) + 200;
// Two-cycle error response puts a floor on the latency
localparam int ERR_LAT     = (`SRAM_WAIT + 1 > 2) ? `SRAM_WAIT + 1 : 2;
localparam int LANES       = `W_DATA / 8;

// Accepted address phase waiting for its data phase
typedef struct packed {
	logic [`W_ADDR-1:0] addr;
	logic [2:0]         size;
	logic               wr;
	int                 cyc;
} pend_t;

logic       clk;
logic       rst_n;
logic       fetch_panic;
core_req_t  fetch_req;
core_req_t  ls_req;
core_resp_t fetch_resp;
core_resp_t ls_resp;

logic [`W_DATA-1:0] ref_mem [`SRAM_WORDS];
pend_t  pend_f[$];
pend_t  pend_l[$];
int     grant_log[$];
integer seed;
int     cycle_cnt = 0;
int     ls_err_cyc = 0;
int     err_cnt = 0;
int     err_base = 0;
int     pass_tests = 0;
int     fail_tests = 0;
string  test_name;

cpu_bus_subsystem UUT (
	.clk           (clk),
	.rst_n         (rst_n),
	.fetch_req_i   (fetch_req),
	.fetch_panic_i (fetch_panic),
	.fetch_resp_o  (fetch_resp),
	.ls_req_i      (ls_req),
	.ls_resp_o     (ls_resp)
);

always #50 clk = ~clk;

// Run length guard
always @(posedge clk) begin
	cycle_cnt = cycle_cnt + 1;
	if (cycle_cnt > CYCLE_LIMIT) begin
		$display("Timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
		$display("STATUS: FAIL");
		$finish;
	end
end

// ------------------------------------------------------------
// Reference model

// Returns {error, read data} and applies writes to the model
function automatic logic [`W_DATA:0] ref_access(input logic [`W_ADDR-1:0] addr,
		input logic [2:0] size, input logic wr, input logic [`W_DATA-1:0] data);
	int idx;
	int lane;
	if (addr >= `W_ADDR'(LANES * `SRAM_WORDS))
		return {1'b1, `W_DATA'(0)};
	idx  = int'(addr / LANES);
	lane = int'(addr % LANES);
	if (wr) begin
		for (int b = 0; b < LANES; b++) begin
			// Byte, halfword or whole word lanes
			if (size >= 3'd2 || (size == 3'd1 && b / 2 == lane / 2) || b == lane)
				ref_mem[idx][8*b +: 8] = data[8*b +: 8];
		end
		return {1'b0, `W_DATA'(0)};
	end
	return {1'b0, ref_mem[idx]};
endfunction

task automatic check_data_phase(input logic is_ls, input core_resp_t resp, input pend_t p,
		input logic [`W_DATA-1:0] wdata, input int err_cyc);
	logic [`W_DATA:0] exp;
	int lat;
	int err_len;
	string port;
	port    = is_ls ? "ls" : "fetch";
	exp     = ref_access(p.addr, p.size, p.wr, wdata);
	lat     = exp[`W_DATA] ? ERR_LAT : `SRAM_WAIT + 1;
	err_len = exp[`W_DATA] ? 2 : 0;
	assert (resp.dph_err === exp[`W_DATA]) else begin
		$display("ERR %0t: %s addr %h dph_err %b, expected %b", $time, port, p.addr,
			resp.dph_err, exp[`W_DATA]);
		err_cnt++;
	end
	assert (cycle_cnt - p.cyc == lat) else begin
		$display("ERR %0t: %s addr %h dph_ready after %0d cycles, expected %0d", $time,
			port, p.addr, cycle_cnt - p.cyc, lat);
		err_cnt++;
	end
	assert (p.wr || exp[`W_DATA] || resp.rdata === exp[`W_DATA-1:0]) else begin
		$display("ERR %0t: %s read %h got %h, expected %h", $time, port, p.addr,
			resp.rdata, exp[`W_DATA-1:0]);
		err_cnt++;
	end
	// Load/store sees its own error in both response cycles and no other
	assert (!is_ls || err_cyc == err_len) else begin
		$display("ERR %0t: ls dph_err high for %0d cycles, expected %0d", $time, err_cyc,
			err_len);
		err_cnt++;
	end
endtask

// ------------------------------------------------------------
// Response checker sampled mid-cycle

always @(negedge clk) begin
	pend_t p;
	if (rst_n) begin
		assert (!(fetch_resp.dph_err && !fetch_resp.dph_ready)) else begin
			$display("ERR %0t: fetch dph_err without dph_ready", $time);
			err_cnt++;
		end
		if (ls_resp.dph_err)
			ls_err_cyc++;
		if (fetch_resp.aph_ready) begin
			p = {fetch_req.addr, fetch_req.size, 1'b0, cycle_cnt};
			pend_f.push_back(p);
			grant_log.push_back(0);
		end
		if (ls_resp.aph_ready) begin
			p = {ls_req.addr, ls_req.size, ls_req.write, cycle_cnt};
			pend_l.push_back(p);
			grant_log.push_back(1);
		end
		if (fetch_resp.dph_ready) begin
			assert (pend_f.size() != 0) else begin
				$display("Fetch port got a data phase it never asked for at %0t", $time);
				err_cnt++;
			end
			if (pend_f.size() != 0)
				check_data_phase(1'b0, fetch_resp, pend_f.pop_front(), '0, 0);
		end
		if (ls_resp.dph_ready) begin
			assert (pend_l.size() != 0) else begin
				$display("Load/store port got a data phase it never asked for at %0t", $time);
				err_cnt++;
			end
			if (pend_l.size() != 0)
				check_data_phase(1'b1, ls_resp, pend_l.pop_front(), ls_req.wdata, ls_err_cyc);
			ls_err_cyc = 0;
		end
	end
end

// ------------------------------------------------------------
// Stimulus helpers entered and left 10 ns after a rising edge

task automatic idle_cycles(input int n);
	repeat (n) begin
		@(posedge clk);
		#10;
	end
endtask

task automatic bus_transfer(input logic is_ls, input logic [`W_ADDR-1:0] addr,
		input logic [2:0] size, input logic wr, input logic [`W_DATA-1:0] data);
	if (is_ls) begin
		ls_req.req   = 1'b1;
		ls_req.addr  = addr;
		ls_req.size  = size;
		ls_req.write = wr;
	end else begin
		fetch_req.req  = 1'b1;
		fetch_req.addr = addr;
		fetch_req.size = size;
	end
	// Request held until the address phase is taken
	do @(negedge clk); while (!(is_ls ? ls_resp.aph_ready : fetch_resp.aph_ready));
	@(posedge clk);
	#10;
	if (is_ls) begin
		ls_req.req   = 1'b0;
		ls_req.wdata = data;
	end else begin
		fetch_req.req = 1'b0;
	end
	do @(negedge clk); while (!(is_ls ? ls_resp.dph_ready : fetch_resp.dph_ready));
	@(posedge clk);
	#10;
endtask

task automatic start_test(input string name);
	test_name = name;
	err_base  = err_cnt;
endtask

task automatic finish_test();
	if (err_cnt == err_base) begin
		pass_tests++;
		$display("test %-10s ok", test_name);
	end else begin
		fail_tests++;
		$display("test %-10s failed with %0d errors", test_name, err_cnt - err_base);
	end
endtask

// ------------------------------------------------------------
// Test sequence

initial begin
	seed        = 32'h9c914833;
	clk         = 1'b0;
	rst_n       = 1'b0;
	fetch_panic = 1'b0;
	fetch_req   = '0;
	ls_req      = '0;
	repeat (2) @(posedge clk);
	#10;
	rst_n = 1'b1;

	// Quiet ports out of reset and then data-phase latency
	start_test("idle");
	repeat (3) begin
		@(negedge clk);
		assert ({fetch_resp.aph_ready, fetch_resp.dph_ready, fetch_resp.dph_err,
			ls_resp.aph_ready, ls_resp.dph_ready, ls_resp.dph_err} === 6'b0) else begin
			$display("ERR %0t: response strobe high with no request", $time);
			err_cnt++;
		end
	end
	@(posedge clk);
	#10;
	bus_transfer(1'b1, 32'hF0, 3'd2, 1'b1, $random(seed));
	bus_transfer(1'b1, 32'hF0, 3'd2, 1'b0, '0);
	finish_test();

	start_test("word_rw");
	for (int i = 0; i < 16; i++)
		bus_transfer(1'b1, 32'(i * 4), 3'd2, 1'b1, $random(seed));
	for (int i = 0; i < 16; i++)
		bus_transfer(1'b1, 32'(i * 4), 3'd2, 1'b0, '0);
	finish_test();

	// Full random word driven but only the chosen lanes may land
	start_test("lanes");
	bus_transfer(1'b1, 32'h80, 3'd2, 1'b1, '0);
	for (int b = 0; b < 4; b++) begin
		bus_transfer(1'b1, 32'h80 + 32'(b), 3'd0, 1'b1, $random(seed));
		bus_transfer(1'b1, 32'h80, 3'd2, 1'b0, '0);
	end
	for (int h = 0; h < 2; h++) begin
		bus_transfer(1'b1, 32'h80 + 32'(2 * h), 3'd1, 1'b1, $random(seed));
		bus_transfer(1'b1, 32'h80, 3'd2, 1'b0, '0);
	end
	finish_test();

	start_test("priority");
	bus_transfer(1'b1, 32'hA0, 3'd2, 1'b1, $random(seed));
	grant_log.delete();
	fork
		bus_transfer(1'b1, 32'hA4, 3'd2, 1'b1, $random(seed));
		bus_transfer(1'b0, 32'hA0, 3'd2, 1'b0, '0);
	join
	assert (grant_log.size() == 2 && grant_log[0] == 1 && grant_log[1] == 0) else begin
		$display("ERR %0t: load/store not granted ahead of fetch", $time);
		err_cnt++;
	end
	// Panic flips the order
	fetch_panic = 1'b1;
	grant_log.delete();
	fork
		bus_transfer(1'b1, 32'hA4, 3'd2, 1'b0, '0);
		bus_transfer(1'b0, 32'hA0, 3'd2, 1'b0, '0);
	join
	fetch_panic = 1'b0;
	assert (grant_log.size() == 2 && grant_log[0] == 0 && grant_log[1] == 1) else begin
		$display("ERR %0t: panic fetch not granted ahead of load/store", $time);
		err_cnt++;
	end
	finish_test();

	// Failed write aliases word 48 if the slave ignores the range
	start_test("errors");
	bus_transfer(1'b1, 32'hC0, 3'd2, 1'b1, $random(seed));
	bus_transfer(1'b1, 32'h4C0, 3'd2, 1'b1, $random(seed));
	bus_transfer(1'b0, 32'h800, 3'd2, 1'b0, '0);
	bus_transfer(1'b1, 32'h500, 3'd2, 1'b0, '0);
	bus_transfer(1'b1, 32'hC0, 3'd2, 1'b0, '0);
	finish_test();

	start_test("mixed");
	fork
		for (int i = 0; i < 12; i++) begin
			idle_cycles($random(seed) & 3);
			bus_transfer(1'b1, 32'($random(seed) & 15) << 2, 3'd2,
				($random(seed) & 1) != 0, $random(seed));
		end
		for (int i = 0; i < 12; i++) begin
			idle_cycles($random(seed) & 3);
			bus_transfer(1'b0, 32'($random(seed) & 15) << 2, 3'd2, 1'b0, '0);
		end
	join
	finish_test();

	$display("tests: %0d passed, %0d failed, %0d errors", pass_tests, fail_tests, err_cnt);
	if (fail_tests == 0 && err_cnt == 0)
		$display("STATUS: PASS");
	else
		$display("STATUS: FAIL");
	$finish;
end

endmodule

/* sim.f */
+incdir+logic
logic/ahb_pkg.sv
logic/ahb_bus_arbiter.sv
logic/ahb_sram_slave.sv
logic/cpu_bus_subsystem.sv
testbench/tb_cpu_bus_subsystem.sv

/* Makefile */
VERILATOR  := verilator
TOP        := tb_cpu_bus_subsystem
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG   := STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
